//--- decode_execute.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_if.sv
rtl/inst_decoder.sv
rtl/idu_exu_regs.sv
rtl/exec_unit.sv
rtl/decode_execute.sv
verification/decode_execute_tb.sv

//--- verification/decode_execute_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

module decode_execute_tb
    import rv_isa_pkg::*;
();

    localparam int N_ALU   = 40;
    localparam int N_BR    = 30;
    localparam int N_SYS   = 12;
    localparam int N_MEM   = 16;
    localparam int N_STALL = 60;
    localparam int N_TOTAL = N_ALU + 3 + N_BR + N_SYS + N_MEM + N_STALL;

    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic [`REG_AW-1:0] rd;
        logic [`CSR_AW-1:0] csr_addr;
        logic [`XLEN-1:0]   csr_wdata;
        logic [`XLEN-1:0]   next_pc;
        logic [`XLEN-1:0]   mem_addr;
        logic               wen, csr_wen, redirect, load, store, ebreak, fence_i;
    } exp_t;

    logic clock = 1'b0;
    logic reset;
    logic i_inst_valid, i_rf_valid, i_wb_ready;
    logic [`XLEN-1:0] i_pc, i_inst, i_rs1_data, i_rs2_data, i_mepc, i_mtvec, i_csr_rdata;
    logic o_inst_ready, o_wb_valid, o_wen, o_csr_wen, o_redirect;
    logic o_load, o_store, o_ebreak, o_fence_i;
    logic [`REG_AW-1:0] o_rs1_addr, o_rs2_addr, o_rd;
    logic [`CSR_AW-1:0] o_csr_addr;
    logic [`XLEN-1:0] o_result, o_csr_wdata, o_next_pc, o_mem_addr;

    exp_t       exp_q[$];
    exp_t       head;
    logic       have_head = 1'b0;
    logic       xfer;
    logic [6:0] out_flags, head_flags;
    logic [31:0] lfsr_state = 32'h9dc7;
    logic       stall_on = 1'b0;
    int         error_count = 0, errs_before = 0, pass_count = 0, fail_count = 0;
    int         accepted = 0, retired = 0;

    decode_execute i_decode_execute (.*);

    always #4 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) return $signed(x) >>> y[4:0];
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Expected writeback for one instruction, by the RV32E rules
    function automatic exp_t model(input logic [31:0] inst, pc, a, b, mepc, mtvec, csr);
        exp_t        e;
        logic [2:0]  f3;
        logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;
        e     = '0;
        f3    = inst[14:12];
        imm_i = $signed(inst[31:20]);
        imm_s = $signed({inst[31:25], inst[11:7]});
        imm_b = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
        imm_j = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
        imm_u = {inst[31:12], 12'h000};
        e.rd  = inst[10:7];   // x16..x31 fold onto RV32E
        case (opcode_e'(inst[6:0]))
            OPC_OP:     {e.wen, e.result} = {1'b1, alu(f3, inst[30], a, b)};
            OPC_OP_IMM: {e.wen, e.result} = {1'b1, alu(f3, f3 == 3'd5 && inst[30], a, imm_i)};
            OPC_LUI:    {e.wen, e.result} = {1'b1, imm_u};
            OPC_AUIPC:  {e.wen, e.result} = {1'b1, pc + imm_u};
            OPC_JAL: begin
                {e.wen, e.redirect, e.result} = {2'b11, pc + 32'd4};
                e.next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                {e.wen, e.redirect, e.result} = {2'b11, pc + 32'd4};
                e.next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: {e.redirect, e.next_pc} = {branch_taken(f3, a, b), pc + imm_b};
            OPC_LOAD: begin
                {e.wen, e.load, e.mem_addr} = {2'b11, a + imm_i};
                e.result = a + imm_i;
            end
            OPC_STORE: {e.store, e.mem_addr} = {1'b1, a + imm_s};
            OPC_MISC_MEM: begin
                e.fence_i  = (f3 == 3'd1);
                e.redirect = e.fence_i;
                e.next_pc  = pc + 32'd4;
            end
            OPC_SYSTEM: begin
                if (f3 == 3'd1) begin
                    {e.wen, e.csr_wen, e.csr_addr} = {2'b11, inst[31:20]};
                    {e.result, e.csr_wdata} = {csr, a};
                end else if (inst[31:20] == 12'h000) begin
                    {e.redirect, e.next_pc} = {1'b1, mtvec};
                end else if (inst[31:20] == 12'h302) begin
                    {e.redirect, e.next_pc} = {1'b1, mepc};
                end else if (inst[31:20] == 12'h001) begin
                    e.ebreak = 1'b1;
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] make_inst(input int kind);
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [19:0] up;
        f3  = rand_bits(3);
        rd  = rand_bits(5);
        rs1 = rand_bits(5);
        rs2 = rand_bits(5);
        imm = rand_bits(12);
        up  = rand_bits(20);
        case (kind)
            0: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, OPC_OP};
            end
            1: begin
                if (f3 == 3'd1) imm[11:5] = 7'h00;   // shamt only
                if (f3 == 3'd5) imm[11:5] = imm[10] ? 7'h20 : 7'h00;
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            2: return {up, rd, OPC_LUI};
            3: return {up, rd, OPC_AUIPC};
            4: return {imm[11:5], rs2, rs1, f3[2] ? f3 : {2'b00, f3[0]}, imm[4:0], OPC_BRANCH};
            5: return {up, rd, OPC_JAL};
            6: return {imm, rs1, 3'b000, rd, OPC_JALR};
            7: return {imm, rs1, 3'b010, rd, OPC_LOAD};
            8: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            9: return {imm, rs1, 3'b001, rd, OPC_SYSTEM};   // csrrw
            10: return 32'h0000_0073;   // ecall
            11: return 32'h3020_0073;   // mret
            12: return 32'h0010_0073;   // ebreak
            default: return 32'h0000_100f;   // fence.i
        endcase
    endfunction

    task automatic drive_stalls();
        i_rf_valid = stall_on ? rand_bits(2) != 0 : 1'b1;
        i_wb_ready = stall_on ? rand_bits(2) != 0 : 1'b1;
    endtask

    // Holds the instruction until the DUT takes it
    task automatic issue(input logic [31:0] inst);
        @(negedge clock);
        i_inst       = inst;
        i_pc         = rand_bits(32) & ~32'd3;
        i_rs1_data   = rand_bits(32);
        i_rs2_data   = (rand_bits(2) == 0) ? i_rs1_data : rand_bits(32);
        i_inst_valid = 1'b1;
        drive_stalls();
        #1;
        while (!o_inst_ready) begin
            @(negedge clock);
            drive_stalls();
            #1;
        end
        exp_q.push_back(model(i_inst, i_pc, i_rs1_data, i_rs2_data, i_mepc, i_mtvec,
                              i_csr_rdata));
        accepted++;
    endtask

    task automatic drain();
        @(negedge clock);
        i_inst_valid = 1'b0;
        drive_stalls();
        while (exp_q.size() != 0) begin
            @(negedge clock);
            drive_stalls();
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == errs_before) begin
            pass_count++;
            $display("Test %-7s passed", name);
        end else begin
            fail_count++;
            $display("Test %-7s FAILED with %0d errors", name, error_count - errs_before);
        end
        errs_before = error_count;
    endtask

    task automatic mismatch(input string field, input logic [31:0] got, input logic [31:0] want);
        $display("Mismatch at %0t: %s got %h expected %h", $time, field, got, want);
        error_count++;
    endtask

    function automatic logic [6:0] flags_of(input exp_t e);
        return {e.wen, e.csr_wen, e.redirect, e.load, e.store, e.ebreak, e.fence_i};
    endfunction

    // Queue head follows retired results
    always @(posedge clock) begin
        if (!reset && o_wb_valid && i_wb_ready) begin
            retired++;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
        have_head <= exp_q.size() != 0;
        head      <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    assign xfer       = o_wb_valid && i_wb_ready && have_head;
    assign out_flags  = {o_wen, o_csr_wen, o_redirect, o_load, o_store, o_ebreak, o_fence_i};
    assign head_flags = flags_of(head);

    a_flags: assert property (@(posedge clock) disable iff (reset)
        xfer |-> out_flags == head_flags)
        else mismatch("flags", $sampled(out_flags), $sampled(head_flags));
    a_result: assert property (@(posedge clock) disable iff (reset)
        xfer && head.wen |-> o_result == head.result)
        else mismatch("o_result", $sampled(o_result), $sampled(head.result));
    a_rd: assert property (@(posedge clock) disable iff (reset)
        xfer && head.wen |-> o_rd == head.rd)
        else mismatch("o_rd", $sampled(o_rd), $sampled(head.rd));
    a_csr_addr: assert property (@(posedge clock) disable iff (reset)
        xfer && head.csr_wen |-> o_csr_addr == head.csr_addr)
        else mismatch("o_csr_addr", $sampled(o_csr_addr), $sampled(head.csr_addr));
    a_csr_wdata: assert property (@(posedge clock) disable iff (reset)
        xfer && head.csr_wen |-> o_csr_wdata == head.csr_wdata)
        else mismatch("o_csr_wdata", $sampled(o_csr_wdata), $sampled(head.csr_wdata));
    a_next_pc: assert property (@(posedge clock) disable iff (reset)
        xfer && head.redirect |-> o_next_pc == head.next_pc)
        else mismatch("o_next_pc", $sampled(o_next_pc), $sampled(head.next_pc));
    a_mem_addr: assert property (@(posedge clock) disable iff (reset)
        xfer && (head.load || head.store) |-> o_mem_addr == head.mem_addr)
        else mismatch("o_mem_addr", $sampled(o_mem_addr), $sampled(head.mem_addr));
    a_rs_addr: assert property (@(posedge clock) disable iff (reset)
        i_inst_valid |-> o_rs1_addr == i_inst[19:15] % 16 && o_rs2_addr == i_inst[24:20] % 16)
        else mismatch("rs_addr", $sampled({o_rs1_addr, o_rs2_addr}),
                      $sampled({4'(i_inst[19:15] % 16), 4'(i_inst[24:20] % 16)}));

    a_expected: assert property (@(posedge clock) disable iff (reset)
        o_wb_valid && i_wb_ready |-> have_head)
        else begin
            $display("Result retired at %0t with no instruction outstanding", $time);
            error_count++;
        end
    a_rf_gate: assert property (@(posedge clock) disable iff (reset)
        !i_rf_valid |-> !o_inst_ready)
        else begin
            $display("Instruction taken at %0t while operands were not valid", $time);
            error_count++;
        end
    a_wb_hold: assert property (@(posedge clock) disable iff (reset)
        o_wb_valid && !i_wb_ready |=> o_wb_valid && $stable(o_result) && $stable(o_next_pc))
        else begin
            $display("Result changed at %0t while writeback was stalled", $time);
            error_count++;
        end

    initial begin
        reset        = 1'b1;
        i_inst_valid = 1'b0;
        i_pc         = '0;
        i_inst       = '0;
        i_rs1_data   = '0;
        i_rs2_data   = '0;
        i_rf_valid   = 1'b1;
        i_wb_ready   = 1'b1;
        i_mepc       = '0;
        i_mtvec      = '0;
        i_csr_rdata  = '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        @(negedge clock);
        assert (!o_wb_valid && !o_wen && !o_csr_wen && !o_redirect && !o_load && !o_store &&
                o_result == '0)
            else begin
                $display("Outputs not cleared after reset at %0t", $time);
                error_count++;
            end
        end_test("reset");

        issue({7'h20, 5'd2, 5'd1, 3'd0, 5'd5, OPC_OP});   // sub
        issue({7'h20, 5'd2, 5'd1, 3'd5, 5'd6, OPC_OP});   // sra
        issue({7'h00, 5'd2, 5'd1, 3'd3, 5'd7, OPC_OP});   // sltu
        repeat (N_ALU) issue(make_inst(rand_bits(2)));
        drain();
        end_test("alu");

        repeat (N_BR) issue(make_inst(4 + rand_bits(2) % 3));
        drain();
        end_test("branch");

        @(negedge clock);
        i_mepc      = rand_bits(32) & ~32'd3;
        i_mtvec     = rand_bits(32) & ~32'd3;
        i_csr_rdata = rand_bits(32);
        for (int k = 0; k < N_SYS; k++) issue(make_inst(9 + k % 3));
        drain();
        end_test("system");

        repeat (N_MEM) issue(make_inst(rand_bits(1) ? 7 + rand_bits(1) : 12 + rand_bits(1)));
        drain();
        end_test("memory");

        stall_on = 1'b1;
        repeat (N_STALL) issue(make_inst(rand_bits(4) % 14));
        drain();
        stall_on = 1'b0;
        assert (retired == accepted && exp_q.size() == 0)
            else begin
                $display("Retired %0d of %0d accepted instructions", retired, accepted);
                error_count++;
            end
        end_test("stall");

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (N_TOTAL * 20 + 8) @(posedge clock);
        $display("Timeout: the pipeline stopped returning results");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/decode_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

module decode_execute (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 i_inst_valid,
    input  wire [`XLEN-1:0]     i_pc,
    input  wire [31:0]          i_inst,
    input  wire [`XLEN-1:0]     i_rs1_data,
    input  wire [`XLEN-1:0]     i_rs2_data,
    input  wire                 i_rf_valid,
    input  wire [`XLEN-1:0]     i_mepc,
    input  wire [`XLEN-1:0]     i_mtvec,
    input  wire [`XLEN-1:0]     i_csr_rdata,
    input  wire                 i_wb_ready,
    output wire                 o_inst_ready,
    output wire [`REG_AW-1:0]   o_rs1_addr,
    output wire [`REG_AW-1:0]   o_rs2_addr,
    output wire                 o_wb_valid,
    output wire [`XLEN-1:0]     o_result,
    output wire [`REG_AW-1:0]   o_rd,
    output wire                 o_wen,
    output wire                 o_csr_wen,
    output wire [`CSR_AW-1:0]   o_csr_addr,
    output wire [`XLEN-1:0]     o_csr_wdata,
    output wire                 o_redirect,
    output wire [`XLEN-1:0]     o_next_pc,
    output wire [`XLEN-1:0]     o_mem_addr,
    output wire                 o_load,
    output wire                 o_store,
    output wire                 o_ebreak,
    output wire                 o_fence_i
);

    stage_if dec_bus (.clock(clock), .reset(reset));
    stage_if exu_bus (.clock(clock), .reset(reset));

    inst_decoder u_inst_decoder (
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_inst_valid (i_inst_valid),
        .i_rs1_data   (i_rs1_data),
        .i_rs2_data   (i_rs2_data),
        .o_inst_ready (o_inst_ready),
        .o_rs1_addr   (o_rs1_addr),
        .o_rs2_addr   (o_rs2_addr),
        .dec_bus      (dec_bus.producer)
    );

    idu_exu_regs u_idu_exu_regs (
        .clock       (clock),
        .reset       (reset),
        .i_rf_valid  (i_rf_valid),
        .i_mepc      (i_mepc),
        .i_mtvec     (i_mtvec),
        .i_csr_rdata (i_csr_rdata),
        .dec_bus     (dec_bus.consumer),
        .exu_bus     (exu_bus.producer)
    );

    exec_unit u_exec_unit (
        .clock       (clock),
        .reset       (reset),
        .exu_bus     (exu_bus.consumer),
        .i_wb_ready  (i_wb_ready),
        .o_wb_valid  (o_wb_valid),
        .o_result    (o_result),
        .o_rd        (o_rd),
        .o_wen       (o_wen),
        .o_csr_wen   (o_csr_wen),
        .o_csr_addr  (o_csr_addr),
        .o_csr_wdata (o_csr_wdata),
        .o_redirect  (o_redirect),
        .o_next_pc   (o_next_pc),
        .o_mem_addr  (o_mem_addr),
        .o_load      (o_load),
        .o_store     (o_store),
        .o_ebreak    (o_ebreak),
        .o_fence_i   (o_fence_i)
    );

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

module exec_unit
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  wire                 clock,
    input  wire                 reset,
    stage_if.consumer           exu_bus,
    input  wire                 i_wb_ready,
    output logic                o_wb_valid,
    output logic [`XLEN-1:0]    o_result,
    output logic [`REG_AW-1:0]  o_rd,
    output logic                o_wen,
    output logic                o_csr_wen,
    output logic [`CSR_AW-1:0]  o_csr_addr,
    output logic [`XLEN-1:0]    o_csr_wdata,
    output logic                o_redirect,
    output logic [`XLEN-1:0]    o_next_pc,
    output logic [`XLEN-1:0]    o_mem_addr,
    output logic                o_load,
    output logic                o_store,
    output logic                o_ebreak,
    output logic                o_fence_i
);

    ctrl_t              ctrl;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   sum;
    logic [`XLEN-1:0]   sra_out;
    logic [`XLEN-1:0]   alu_out;
    logic               alu_lt;
    logic               br_lt;
    logic               taken;
    logic [`XLEN-1:0]   pc_plus4;
    logic [`XLEN-1:0]   result_d;
    logic [`XLEN-1:0]   next_pc_d;
    logic               redirect_d;

    assign ctrl     = exu_bus.ctrl;
    assign op_a     = ctrl.src_sel.a_pc ? exu_bus.pc : exu_bus.src1;
    assign op_b     = ctrl.src_sel.b_imm ? exu_bus.imm : exu_bus.src2;
    assign sum      = ctrl.alt ? op_a - op_b : op_a + op_b;
    assign sra_out  = $signed(op_a) >>> op_b[4:0];
    assign pc_plus4 = exu_bus.pc + 32'd4;

    assign alu_lt = ctrl.if_unsigned ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));
    assign br_lt  = ctrl.if_unsigned ? (exu_bus.src1 < exu_bus.src2) :
                                       ($signed(exu_bus.src1) < $signed(exu_bus.src2));

    always_comb begin
        case (ctrl.exu_opt)
            ALU_ADD:           alu_out = sum;
            ALU_SLL:           alu_out = op_a << op_b[4:0];
            ALU_SLT, ALU_SLTU: alu_out = {31'b0, alu_lt};
            ALU_XOR:           alu_out = op_a ^ op_b;
            ALU_SRL:           alu_out = ctrl.alt ? sra_out : op_a >> op_b[4:0];
            ALU_OR:            alu_out = op_a | op_b;
            default:           alu_out = op_a & op_b;
        endcase
    end

    always_comb begin
        case (br_fn_e'(ctrl.exu_opt))
            BR_EQ:          taken = (exu_bus.src1 == exu_bus.src2);
            BR_NE:          taken = (exu_bus.src1 != exu_bus.src2);
            BR_LT, BR_LTU:  taken = br_lt;
            BR_GE, BR_GEU:  taken = !br_lt;
            default:        taken = 1'b0;
        endcase
    end

    assign result_d = (ctrl.jal || ctrl.jalr) ? pc_plus4 :
                      ctrl.csr_src_sel        ? exu_bus.src2 :
                      alu_out;

    always_comb begin
        next_pc_d = pc_plus4;   // fence.i refetches the next instruction
        if ((ctrl.brch && taken) || ctrl.jal) begin
            next_pc_d = exu_bus.pc + exu_bus.imm;
        end else if (ctrl.jalr) begin
            next_pc_d = (exu_bus.src1 + exu_bus.imm) & ~32'd1;
        end else if (ctrl.ecall || ctrl.mret) begin
            next_pc_d = exu_bus.src1;
        end
    end

    assign redirect_d = (ctrl.brch && taken) || ctrl.jal || ctrl.jalr ||
                        ctrl.ecall || ctrl.mret || ctrl.fence_i;

    assign exu_bus.ready = !o_wb_valid || i_wb_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            o_wb_valid  <= 1'b0;
            o_result    <= '0;
            o_rd        <= '0;
            o_wen       <= 1'b0;
            o_csr_wen   <= 1'b0;
            o_csr_addr  <= '0;
            o_csr_wdata <= '0;
            o_redirect  <= 1'b0;
            o_next_pc   <= '0;
            o_mem_addr  <= '0;
            o_load      <= 1'b0;
            o_store     <= 1'b0;
            o_ebreak    <= 1'b0;
            o_fence_i   <= 1'b0;
        end else if (exu_bus.ready) begin
            // Empty slot when nothing arrives
            o_wb_valid  <= exu_bus.valid;
            o_result    <= exu_bus.valid ? result_d : '0;
            o_rd        <= exu_bus.valid ? ctrl.rd : '0;
            o_wen       <= exu_bus.valid && ctrl.wen;
            o_csr_wen   <= exu_bus.valid && ctrl.csr_wen;
            o_csr_addr  <= exu_bus.valid ? ctrl.csr_addr : '0;
            o_csr_wdata <= exu_bus.valid ? exu_bus.src1 : '0;
            o_redirect  <= exu_bus.valid && redirect_d;
            o_next_pc   <= exu_bus.valid ? next_pc_d : '0;
            o_mem_addr  <= exu_bus.valid ? exu_bus.src1 + exu_bus.imm : '0;
            o_load      <= exu_bus.valid && ctrl.load;
            o_store     <= exu_bus.valid && ctrl.store;
            o_ebreak    <= exu_bus.valid && ctrl.ebreak;
            o_fence_i   <= exu_bus.valid && ctrl.fence_i;
        end
    end

    a_wb_hold: assert property (@(posedge clock) disable iff (reset)
        o_wb_valid && !i_wb_ready |=>
            o_wb_valid && $stable({o_result, o_rd, o_wen, o_csr_wen, o_csr_addr, o_csr_wdata,
                                   o_redirect, o_next_pc, o_mem_addr, o_load, o_store}));

    a_redirect_valid: assert property (@(posedge clock) disable iff (reset)
        o_redirect |-> o_wb_valid);

endmodule

`default_nettype wire

//--- rtl/idu_exu_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

module idu_exu_regs (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 i_rf_valid,
    input  wire [`XLEN-1:0]     i_mepc,
    input  wire [`XLEN-1:0]     i_mtvec,
    input  wire [`XLEN-1:0]     i_csr_rdata,
    stage_if.consumer           dec_bus,
    stage_if.producer           exu_bus
);

    logic               full;
    logic               take;
    logic               drain;
    logic [`XLEN-1:0]   sel_src1;
    logic [`XLEN-1:0]   sel_src2;

    // Operands are only trusted while the register file says so
    assign dec_bus.ready = i_rf_valid && (!full || exu_bus.ready);
    assign exu_bus.valid = full;

    assign take  = dec_bus.valid && dec_bus.ready;
    assign drain = exu_bus.valid && exu_bus.ready;

    assign sel_src1 = dec_bus.ctrl.ecall ? i_mtvec :
                      dec_bus.ctrl.mret  ? i_mepc  :
                      dec_bus.src1;

    assign sel_src2 = dec_bus.ctrl.csr_src_sel ? i_csr_rdata : dec_bus.src2;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exu_bus.pc   <= '0;
            exu_bus.src1 <= '0;
            exu_bus.src2 <= '0;
            exu_bus.imm  <= '0;
            exu_bus.ctrl <= '0;
        end else if (take) begin
            exu_bus.pc   <= dec_bus.pc;
            exu_bus.src1 <= sel_src1;
            exu_bus.src2 <= sel_src2;
            exu_bus.imm  <= dec_bus.imm;
            exu_bus.ctrl <= dec_bus.ctrl;
        end else if (drain) begin
            // Bubble
            exu_bus.pc   <= '0;
            exu_bus.src1 <= '0;
            exu_bus.src2 <= '0;
            exu_bus.imm  <= '0;
            exu_bus.ctrl <= '0;
        end
    end

    // An entry only appears after a capture
    a_valid_from_capture: assert property (@(posedge clock) disable iff (reset)
        !full ##1 exu_bus.valid |-> $past(dec_bus.valid && dec_bus.ready));

    a_hold_entry: assert property (@(posedge clock) disable iff (reset)
        exu_bus.valid && !exu_bus.ready |=>
            exu_bus.valid &&
            $stable({exu_bus.pc, exu_bus.src1, exu_bus.src2, exu_bus.imm, exu_bus.ctrl}));

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

module inst_decoder
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  wire [31:0]          i_inst,
    input  wire [`XLEN-1:0]     i_pc,
    input  wire                 i_inst_valid,
    input  wire [`XLEN-1:0]     i_rs1_data,
    input  wire [`XLEN-1:0]     i_rs2_data,
    output logic                o_inst_ready,
    output logic [`REG_AW-1:0]  o_rs1_addr,
    output logic [`REG_AW-1:0]  o_rs2_addr,
    stage_if.producer           dec_bus
);

    logic [2:0]         funct3;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;
    logic [`XLEN-1:0]   imm;
    logic               zero_src1;   // LUI adds imm to zero
    ctrl_t              ctrl;

    assign funct3     = i_inst[14:12];
    assign o_rs1_addr = i_inst[18:15];   // Upper bit dropped for RV32E
    assign o_rs2_addr = i_inst[23:20];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
                    1'b0};

    always_comb begin
        ctrl      = '0;
        imm       = '0;
        zero_src1 = 1'b0;
        ctrl.rd   = i_inst[10:7];
        case (opcode_e'(i_inst[6:0]))
            OPC_OP: begin
                ctrl.exu_opt     = alu_fn_e'(funct3);
                ctrl.alt         = i_inst[30];
                ctrl.if_unsigned = (funct3 == 3'b011);
                ctrl.wen         = 1'b1;
            end
            OPC_OP_IMM: begin
                imm                    = imm_i;
                ctrl.exu_opt           = alu_fn_e'(funct3);
                ctrl.alt               = (funct3 == 3'b101) && i_inst[30];   // srai only
                ctrl.if_unsigned       = (funct3 == 3'b011);
                ctrl.src_sel.b_imm     = 1'b1;
                ctrl.wen               = 1'b1;
            end
            OPC_LUI: begin
                imm                = imm_u;
                zero_src1          = 1'b1;
                ctrl.src_sel.b_imm = 1'b1;
                ctrl.wen           = 1'b1;
            end
            OPC_AUIPC: begin
                imm          = imm_u;
                ctrl.src_sel = '{b_imm: 1'b1, a_pc: 1'b1};
                ctrl.wen     = 1'b1;
            end
            OPC_JAL: begin
                imm          = imm_j;
                ctrl.src_sel = '{b_imm: 1'b1, a_pc: 1'b1};
                ctrl.jal     = 1'b1;
                ctrl.wen     = 1'b1;
            end
            OPC_JALR: begin
                imm                = imm_i;
                ctrl.src_sel.b_imm = 1'b1;
                ctrl.jalr          = 1'b1;
                ctrl.wen           = 1'b1;
            end
            OPC_BRANCH: begin
                imm              = imm_b;
                ctrl.exu_opt     = alu_fn_e'(funct3);
                ctrl.if_unsigned = funct3[1];
                ctrl.brch        = 1'b1;
            end
            OPC_LOAD: begin
                imm                = imm_i;
                ctrl.src_sel.b_imm = 1'b1;
                ctrl.load          = 1'b1;
                ctrl.wen           = 1'b1;
            end
            OPC_STORE: begin
                imm                = imm_s;
                ctrl.src_sel.b_imm = 1'b1;
                ctrl.store         = 1'b1;
            end
            OPC_MISC_MEM: ctrl.fence_i = (funct3 == 3'b001);
            OPC_SYSTEM: begin
                if (funct3 == 3'b001) begin   // CSRRW
                    ctrl.csr_addr    = i_inst[31:20];
                    ctrl.csr_src_sel = 1'b1;
                    ctrl.csr_wen     = 1'b1;
                    ctrl.wen         = 1'b1;
                end else if (funct3 == 3'b000) begin
                    ctrl.ecall  = (i_inst[31:20] == 12'h000);
                    ctrl.ebreak = (i_inst[31:20] == 12'h001);
                    ctrl.mret   = (i_inst[31:20] == 12'h302);
                end
            end
            default: ctrl = '0;
        endcase
    end

    assign dec_bus.valid = i_inst_valid;
    assign dec_bus.pc    = i_pc;
    assign dec_bus.src1  = zero_src1 ? '0 : i_rs1_data;
    assign dec_bus.src2  = i_rs2_data;
    assign dec_bus.imm   = imm;
    assign dec_bus.ctrl  = ctrl;
    assign o_inst_ready  = dec_bus.ready;

    // Fetch side must hold a stalled instruction
    a_hold_inst: assert property (@(posedge dec_bus.clock) disable iff (dec_bus.reset)
        dec_bus.valid && !dec_bus.ready |=>
            dec_bus.valid && $stable({dec_bus.pc, dec_bus.imm, dec_bus.ctrl}));

endmodule

`default_nettype wire

//--- rtl/stage_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_execute_defines.svh"

interface stage_if
    import pipe_pkg::*;
(
    input wire clock,
    input wire reset
);

    logic               valid;
    logic               ready;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;
    logic [`XLEN-1:0]   imm;
    ctrl_t              ctrl;

    modport producer (
        input  clock, reset, ready,
        output valid, pc, src1, src2, imm, ctrl
    );

    modport consumer (
        input  clock, reset, valid, pc, src1, src2, imm, ctrl,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

`include "decode_execute_defines.svh"

package pipe_pkg;

    import rv_isa_pkg::*;

    // Operand source select
    typedef struct packed {
        logic b_imm;   // Operand B is the immediate
        logic a_pc;    // Operand A is the pc
    } src_sel_t;

    typedef struct packed {
        alu_fn_e             exu_opt;   // funct3 for branches as well
        logic                alt;       // sub / sra
        logic                if_unsigned;
        src_sel_t            src_sel;
        logic                csr_src_sel;
        logic [`REG_AW-1:0]  rd;
        logic [`CSR_AW-1:0]  csr_addr;
        logic                wen;
        logic                csr_wen;
        logic                load;
        logic                store;
        logic                brch;
        logic                jal;
        logic                jalr;
        logic                mret;
        logic                ecall;
        logic                ebreak;
        logic                fence_i;
    } ctrl_t;

endpackage

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,   // fence.i lives here
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // Same encoding as funct3 of OP and OP-IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_fn_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_fn_e;

endpackage

`default_nettype wire

//--- rtl/decode_execute_defines.svh
`ifndef DECODE_EXECUTE_DEFINES_SVH
`define DECODE_EXECUTE_DEFINES_SVH

// Data and address width
`define XLEN 32

// RV32E has 16 registers
`define REG_AW 4

`define CSR_AW 12

`endif
